// ==== hdl/accum_addr_gen.sv ====
module accum_addr_gen
    import accum_cfg_pkg::*;
    import accum_ctrl_pkg::*;
#(
    parameter int NUM_LANES = DEF_NUM_LANES,
    parameter int ADDR_W    = 2
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           wdata_available,
    input  kdim_t          k_dimension,
    input  logic           buffer_select,
    accum_wr_if.src        cmd,
    output logic           pool_bank,
    output logic           start_pooling,
    output logic           done_pooling
);

    localparam logic [ADDR_W-1:0] LAST_PH = ADDR_W'(NUM_LANES - 1);

    seq_state_t        state;
    kdim_t             wr_cnt;
    kdim_t             burst_k;
    kdim_t             cur_k;
    logic              wr_bank;
    logic              burst_bank;
    logic              burst_last;
    logic [ADDR_W-1:0] ph_cnt;

    // Settings are taken straight from the inputs on the first valid cycle
    assign cur_k      = (wr_cnt == '0) ? k_dimension : burst_k;
    assign burst_bank = (wr_cnt == '0) ? buffer_select : wr_bank;
    assign burst_last = wdata_available && (wr_cnt == kdim_t'(cur_k - 1'b1));

    always_ff @(posedge clk) begin
        if (wdata_available && wr_cnt == '0) begin
            burst_k <= k_dimension;
            wr_bank <= buffer_select;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_cnt    <= '0;
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= wdata_available;
            if (!wdata_available || burst_last)
                wr_cnt <= '0;
            else
                wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // Lane 0 command, address wraps every tile
    always_ff @(posedge clk) begin
        cmd.addr  <= wr_cnt[ADDR_W-1:0];
        cmd.first <= wr_cnt < kdim_t'(NUM_LANES);
        cmd.bank  <= burst_bank;
    end

    //////////////////////////////////////////////////////////////////////
    // Drain and pool phases
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= SEQ_IDLE;
            ph_cnt        <= '0;
            pool_bank     <= 1'b0;
            start_pooling <= 1'b0;
            done_pooling  <= 1'b0;
        end else begin
            start_pooling <= 1'b0;
            done_pooling  <= 1'b0;
            if (burst_last)
                pool_bank <= burst_bank;
            case (state)
                SEQ_IDLE: begin
                    if (wdata_available)
                        state <= SEQ_ACCUM;
                end
                SEQ_ACCUM: begin
                    if (burst_last) begin
                        state  <= SEQ_DRAIN;
                        ph_cnt <= '0;
                    end
                end
                SEQ_DRAIN: begin
                    ph_cnt <= ph_cnt + 1'b1;
                    if (ph_cnt == LAST_PH) begin
                        state         <= SEQ_POOL;
                        start_pooling <= 1'b1;
                    end
                end
                SEQ_POOL: begin
                    ph_cnt <= ph_cnt + 1'b1;
                    // A burst into the other bank may already be running
                    if (ph_cnt == LAST_PH) begin
                        done_pooling <= 1'b1;
                        if (burst_last)
                            state <= SEQ_DRAIN;
                        else if (wdata_available)
                            state <= SEQ_ACCUM;
                        else
                            state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    a_kdim_legal: assert property (@(posedge clk) disable iff (!resetn)
        wdata_available && wr_cnt == '0 |->
            k_dimension != '0 && k_dimension[ADDR_W-1:0] == '0);

    a_burst_held: assert property (@(posedge clk) disable iff (!resetn)
        wdata_available && !burst_last |=> wdata_available);

    // Pool bank is being read by every lane
    a_no_pool_overwrite: assert property (@(posedge clk) disable iff (!resetn)
        state == SEQ_POOL && wdata_available && wr_cnt == '0 |->
            buffer_select != pool_bank);

endmodule

// ==== hdl/accum_cfg_pkg.sv ====
package accum_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    // Accumulated word, sums wrap at this width
    localparam int DATA_W = 8;

    typedef logic [DATA_W-1:0] data_t;

    //////////////////////////////////////////////////////////////////////
    // Burst geometry
    //////////////////////////////////////////////////////////////////////

    // K dimension of the multiply, one valid cycle per K step
    localparam int KDIM_W = 8;

    typedef logic [KDIM_W-1:0] kdim_t;

    // Column lanes of the array, also the words per bank
    localparam int DEF_NUM_LANES = 4;

endpackage

// ==== hdl/accum_ctrl_pkg.sv ====
package accum_ctrl_pkg;

    // Burst sequencer phases
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ACCUM = 2'd1,
        // Waiting for the skewed lanes to finish their writes
        SEQ_DRAIN = 2'd2,
        // Bank open to the pooling unit
        SEQ_POOL  = 2'd3
    } seq_state_t;

endpackage

// ==== hdl/accum_lane.sv ====
module accum_lane
    import accum_cfg_pkg::*;
#(
    parameter int NUM_LANES = DEF_NUM_LANES,
    parameter int ADDR_W    = 2
) (
    input  logic              clk,
    accum_wr_if.dst           cmd,
    input  data_t             wdata,
    input  logic              pool_bank,
    input  logic [ADDR_W-1:0] pool_raddr,
    output data_t             pool_rdata
);

    data_t ping_mem [NUM_LANES];
    data_t pong_mem [NUM_LANES];
    data_t wdata_q;
    data_t stored;
    data_t next_word;

    // Input word lines up with the registered command
    always_ff @(posedge clk) begin
        wdata_q <= wdata;
    end

    //////////////////////////////////////////////////////////////////////
    // Read-modify-write
    //////////////////////////////////////////////////////////////////////

    assign stored    = cmd.bank ? ping_mem[cmd.addr] : pong_mem[cmd.addr];
    assign next_word = cmd.first ? wdata_q : data_t'(wdata_q + stored);

    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            if (cmd.bank)
                ping_mem[cmd.addr] <= next_word;
            else
                pong_mem[cmd.addr] <= next_word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pool read port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pool_bank)
            pool_rdata <= ping_mem[pool_raddr];
        else
            pool_rdata <= pong_mem[pool_raddr];
    end

endmodule

// ==== hdl/accum_skew.sv ====
module accum_skew #(
    parameter int NUM_LANES = 4,
    parameter int ADDR_W    = 2
) (
    input  logic    clk,
    input  logic    resetn,
    accum_wr_if.dst head,
    accum_wr_if.src tails [NUM_LANES-1]
);

    // Record layout is valid, first, bank, addr from the top bit down
    localparam int REC_W = ADDR_W + 3;

    logic [REC_W-1:0] pipe [1:NUM_LANES-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 1; s < NUM_LANES; s++)
                pipe[s] <= '0;
        end else begin
            pipe[1] <= {head.valid, head.first, head.bank, head.addr};
            for (int s = 2; s < NUM_LANES; s++)
                pipe[s] <= pipe[s-1];
        end
    end

    // Stage j feeds lane j
    for (genvar j = 1; j < NUM_LANES; j++) begin : g_tap
        assign tails[j-1].valid = pipe[j][REC_W-1];
        assign tails[j-1].first = pipe[j][REC_W-2];
        assign tails[j-1].bank  = pipe[j][REC_W-3];
        assign tails[j-1].addr  = pipe[j][ADDR_W-1:0];
    end

endmodule

// ==== hdl/accum_wr_if.sv ====
interface accum_wr_if #(
    parameter int ADDR_W = 2
);

    logic              valid;
    logic [ADDR_W-1:0] addr;
    // Overwrite instead of add
    logic              first;
    // 1 selects ping, 0 selects pong
    logic              bank;

    modport src (
        output valid, addr, first, bank
    );

    modport dst (
        input valid, addr, first, bank
    );

endinterface

// ==== hdl/accumulator_top.sv ====
module accumulator_top
    import accum_cfg_pkg::*;
#(
    parameter int   NUM_LANES = DEF_NUM_LANES,
    localparam int  ADDR_W    = $clog2(NUM_LANES)
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              wdata_available,
    input  kdim_t                             k_dimension,
    input  logic                              buffer_select,
    input  data_t [NUM_LANES-1:0]             wdata,
    input  logic  [NUM_LANES-1:0][ADDR_W-1:0] pool_raddr,
    output data_t [NUM_LANES-1:0]             pool_rdata,
    output logic                              start_pooling,
    output logic                              done_pooling
);

    logic pool_bank;

    // Lane 0 command, then one delayed copy per remaining lane
    accum_wr_if #(.ADDR_W(ADDR_W)) cmd_head ();
    accum_wr_if #(.ADDR_W(ADDR_W)) cmd_tail [NUM_LANES-1] ();

    accum_addr_gen #(
        .NUM_LANES (NUM_LANES),
        .ADDR_W    (ADDR_W)
    ) addr_gen_i (
        .clk             (clk),
        .resetn          (resetn),
        .wdata_available (wdata_available),
        .k_dimension     (k_dimension),
        .buffer_select   (buffer_select),
        .cmd             (cmd_head.src),
        .pool_bank       (pool_bank),
        .start_pooling   (start_pooling),
        .done_pooling    (done_pooling)
    );

    accum_skew #(
        .NUM_LANES (NUM_LANES),
        .ADDR_W    (ADDR_W)
    ) skew_i (
        .clk    (clk),
        .resetn (resetn),
        .head   (cmd_head.dst),
        .tails  (cmd_tail)
    );

    for (genvar j = 0; j < NUM_LANES; j++) begin : g_lane
        if (j == 0) begin : g_head
            accum_lane #(
                .NUM_LANES (NUM_LANES),
                .ADDR_W    (ADDR_W)
            ) lane_i (
                .clk        (clk),
                .cmd        (cmd_head.dst),
                .wdata      (wdata[j]),
                .pool_bank  (pool_bank),
                .pool_raddr (pool_raddr[j]),
                .pool_rdata (pool_rdata[j])
            );
        end else begin : g_tail
            accum_lane #(
                .NUM_LANES (NUM_LANES),
                .ADDR_W    (ADDR_W)
            ) lane_i (
                .clk        (clk),
                .cmd        (cmd_tail[j-1]),
                .wdata      (wdata[j]),
                .pool_bank  (pool_bank),
                .pool_raddr (pool_raddr[j]),
                .pool_rdata (pool_rdata[j])
            );
        end
    end

endmodule

// ==== project.f ====
hdl/accum_cfg_pkg.sv
hdl/accum_ctrl_pkg.sv
hdl/accum_wr_if.sv
hdl/accum_addr_gen.sv
hdl/accum_skew.sv
hdl/accum_lane.sv
hdl/accumulator_top.sv
testbench/tb_accumulator.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_accumulator -f project.f

out=$(./obj_dir/Vtb_accumulator 2>&1) || true
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
else
    exit 1
fi

// ==== testbench/accum_golden.txt ====
// Record: k_dimension buffer_select overlap, then k rows of lane inputs 0..3,
// then 4 rows of expected sums, one row per address with lanes 0..3; 00 ends
04 01 00
11 22 33 44
55 66 77 88
99 aa bb cc
dd ee ff 01
11 22 33 44
55 66 77 88
99 aa bb cc
dd ee ff 01
10 00 00
c0 d0 e0 f0
c1 d1 e1 f1
c2 d2 e2 f2
c3 d3 e3 f3
c4 d4 e4 f4
c5 d5 e5 f5
c6 d6 e6 f6
c7 d7 e7 f7
c8 d8 e8 f8
c9 d9 e9 f9
ca da ea fa
cb db eb fb
cc dc ec fc
cd dd ed fd
ce de ee fe
cf df ef ff
18 58 98 d8
1c 5c 9c dc
20 60 a0 e0
24 64 a4 e4
04 01 01
01 02 03 04
05 06 07 08
09 0a 0b 0c
0d 0e 0f 10
01 02 03 04
05 06 07 08
09 0a 0b 0c
0d 0e 0f 10
04 01 00
21 43 65 87
0f 1e 2d 3c
80 80 80 80
7f 01 fe 02
21 43 65 87
0f 1e 2d 3c
80 80 80 80
7f 01 fe 02
00 00 00

// ==== testbench/tb_accumulator.sv ====
module tb_accumulator
    import accum_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N          = DEF_NUM_LANES;
    localparam int AW         = $clog2(N);
    localparam int MAX_BURSTS = 16;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 wdata_available;
    kdim_t                k_dimension;
    logic                 buffer_select;
    data_t [N-1:0]        wdata;
    logic  [N-1:0][AW-1:0] pool_raddr;
    data_t [N-1:0]        pool_rdata;
    logic                 start_pooling;
    logic                 done_pooling;

    data_t gold [0:1023];
    int    num_bursts = 0;
    int    rec_k [MAX_BURSTS];
    logic  rec_bank [MAX_BURSTS];
    logic  rec_overlap [MAX_BURSTS];
    int    in_base [MAX_BURSTS];
    int    exp_base [MAX_BURSTS];
    int    last_edge [MAX_BURSTS];
    int    start_cyc [MAX_BURSTS];
    int    cyc = 0;
    int    start_cnt = 0;
    int    done_cnt = 0;
    int    drive_cnt = 0;
    logic  start_q = 1'b0;
    bit    parsed = 1'b0;

    accumulator_top dut_i (
        .clk             (clk),
        .resetn          (resetn),
        .wdata_available (wdata_available),
        .k_dimension     (k_dimension),
        .buffer_select   (buffer_select),
        .wdata           (wdata),
        .pool_raddr      (pool_raddr),
        .pool_rdata      (pool_rdata),
        .start_pooling   (start_pooling),
        .done_pooling    (done_pooling)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_run(string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    // Each record is k, bank, overlap, then inputs, then expected sums
    task automatic load_golden();
        int p;
        p = 0;
        $readmemh("testbench/accum_golden.txt", gold);
        while (gold[p] !== '0 && num_bursts < MAX_BURSTS) begin
            rec_k[num_bursts]       = int'(gold[p]);
            rec_bank[num_bursts]    = gold[p+1][0];
            rec_overlap[num_bursts] = gold[p+2][0];
            in_base[num_bursts]     = p + 3;
            exp_base[num_bursts]    = p + 3 + rec_k[num_bursts] * N;
            p = exp_base[num_bursts] + N * N;
            num_bursts++;
        end
        assert (num_bursts > 0) else stop_run("golden file holds no bursts");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Lane j sees burst cycle i on the j-th cycle after lane 0
    task automatic drive_burst(int b);
        int k;
        int src;
        k = rec_k[b];
        for (int t = 0; t < k + N - 1; t++) begin
            wdata_available = t < k;
            // Burst settings only hold on the first valid cycle
            k_dimension     = (t == 0) ? kdim_t'(k) : '0;
            buffer_select   = (t == 0) ? rec_bank[b] : !rec_bank[b];
            for (int j = 0; j < N; j++) begin
                src = t - j;
                wdata[j] = (src >= 0 && src < k) ? gold[in_base[b] + src * N + j] : '0;
            end
            if (t == k - 1)
                last_edge[b] = cyc + 1;
            @(negedge clk);
        end
        wdata = '0;
    endtask

    task automatic drive_all();
        for (int b = 0; b < num_bursts; b++) begin
            if (b > 0) begin
                if (rec_overlap[b]) begin
                    wait (start_cnt >= b);
                    @(negedge clk);
                end else begin
                    wait (done_cnt >= b);
                    @(negedge clk);
                    repeat ($urandom % 4) @(negedge clk);
                end
            end
            drive_cnt = b + 1;
            drive_burst(b);
        end
    endtask

    task automatic read_all();
        data_t expected;
        for (int b = 0; b < num_bursts; b++) begin
            wait (start_cnt > b);
            for (int a = 0; a < N; a++) begin
                for (int j = 0; j < N; j++)
                    pool_raddr[j] = AW'(a);
                @(negedge clk);
                for (int j = 0; j < N; j++) begin
                    expected = gold[exp_base[b] + a * N + j];
                    assert (pool_rdata[j] === expected) else
                        stop_run($sformatf(
                            "MISMATCH %0t: burst %0d lane %0d addr %0d got %h exp %h",
                            $time, b, j, a, pool_rdata[j], expected));
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Strobe monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (resetn) begin
            if (start_pooling) begin
                assert (start_cnt < drive_cnt) else
                    stop_run("start_pooling went high with no burst pending");
                assert (!start_q) else stop_run("start_pooling stayed high for two cycles");
                assert (cyc == last_edge[start_cnt] + N) else
                    stop_run($sformatf("MISMATCH %0t: start_pooling at edge %0d, exp %0d",
                        $time, cyc, last_edge[start_cnt] + N));
                start_cyc[start_cnt] = cyc;
                start_cnt++;
            end
            if (done_pooling) begin
                assert (done_cnt < start_cnt) else
                    stop_run("done_pooling went high with no open window");
                assert (cyc == start_cyc[done_cnt] + N) else
                    stop_run($sformatf("MISMATCH %0t: done_pooling at edge %0d, exp %0d",
                        $time, cyc, start_cyc[done_cnt] + N));
                done_cnt++;
            end
            start_q = start_pooling;
        end
    end

    initial begin
        int limit;
        wait (parsed);
        limit = 16 + 24;
        for (int b = 0; b < num_bursts; b++)
            limit += rec_k[b] + 3 * N + 8;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(15881));
        resetn          = 1'b0;
        wdata_available = 1'b0;
        k_dimension     = '0;
        buffer_select   = 1'b0;
        wdata           = '0;
        pool_raddr      = '0;
        load_golden();
        parsed = 1'b1;
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        // The monitor flags any stray strobe in this idle stretch
        repeat (8) @(negedge clk);
        fork
            drive_all();
            read_all();
        join
        repeat (3) @(negedge clk);
        if (done_cnt == num_bursts) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("done_pooling seen %0d times for %0d bursts", done_cnt, num_bursts);
            $display("ERRORS FOUND");
            $fatal(1, "missing done_pooling");
        end
    end

endmodule
